/* crbCommandTable.sv */
//==============================
// crb command code table
// handle and session counts, code validity, processor
//==============================
`timescale 1ns/1ps

module crbCommandTable (
	input tpmCrbPkg::wordT commandCode,
	output tpmCrbPkg::countT handleCount,
	output tpmCrbPkg::countT sessionCount,
	output logic codeValid,
	output logic engineCommand // low for management commands
);

	always_comb
	begin
		codeValid = 1'b1; // only the default arm clears it
		case (commandCode)
			// no auth area at all
			tpmCrbPkg::CcStartup,
			tpmCrbPkg::CcSelfTest,
			tpmCrbPkg::CcGetRandom: {handleCount, sessionCount} = {3'd0, 3'd0};
			tpmCrbPkg::CcClear,
			tpmCrbPkg::CcHierarchyControl: {handleCount, sessionCount} = {3'd1, 3'd1};
			tpmCrbPkg::CcNvRead: {handleCount, sessionCount} = {3'd2, 3'd1}; // auth + index
			tpmCrbPkg::CcActivateCredential: {handleCount, sessionCount} = {3'd2, 3'd2};
			tpmCrbPkg::CcPolicyNV: {handleCount, sessionCount} = {3'd3, 3'd1}; // widest
			default:
			begin
				{handleCount, sessionCount} = {3'd0, 3'd0};
				codeValid = 1'b0; // answered with TPM_RC_COMMAND_CODE
			end
		endcase
	end

	// startup and hierarchy control go to the management block
	assign engineCommand = !(commandCode == tpmCrbPkg::CcStartup ||
		commandCode == tpmCrbPkg::CcHierarchyControl);

endmodule

/* crbSequencer.sv */
//==============================
// crb command sequencer
// parses the command, runs execution handshake
// and streams the fixed 10 byte response
//==============================
`timescale 1ns/1ps

module crbSequencer (
	input logic clock,
	input logic reset_n,
	input logic cmdSend, // command waiting in the buffer
	input logic rspReady, // engine result, level
	input logic execAck, // execDone seen
	input tpmCrbPkg::wordT cmdSize,
	input tpmCrbPkg::wordT responseCode,
	input tpmCrbPkg::byteT cmdByteIn, // valid on byteStrobe
	output logic xferStart,
	output logic xferRestart,
	output tpmCrbPkg::bufAddrT xferSize,
	input tpmCrbPkg::bufAddrT xferAddr,
	input tpmCrbPkg::bufAddrT xferRel,
	input logic byteStrobe,
	input logic xferDone,
	output tpmCrbPkg::wordT commandCode,
	input tpmCrbPkg::countT handleCount,
	input tpmCrbPkg::countT sessionCount,
	input logic codeValid,
	input logic engineCommand,
	output tpmCrbPkg::bufAddrT cmdOutAddr,
	output tpmCrbPkg::bufAddrT rspOutAddr,
	output tpmCrbPkg::byteT rspByteOut,
	output logic rspSend, cmdDone, rspDone, execStart, execDone,
	output tpmCrbPkg::halfT commandTag,
	output tpmCrbPkg::wordT handle0, handle1, handle2,
	output tpmCrbPkg::wordT sessionHandle0, sessionHandle1, sessionHandle2,
	output tpmCrbPkg::wordT authSize,
	output tpmCrbPkg::byteT sessionAttributes0, sessionAttributes1, sessionAttributes2,
	output tpmCrbPkg::halfT sessionHmacSize0, sessionHmacSize1, sessionHmacSize2,
	output logic sessionValid0, sessionValid1, sessionValid2
);

	tpmCrbPkg::crbStateT state;
	tpmCrbPkg::countT idx; // handle or session loop index
	tpmCrbPkg::wordT handleReg [tpmCrbPkg::MaxHandles];
	tpmCrbPkg::wordT sessHandleReg [tpmCrbPkg::MaxSessions];
	tpmCrbPkg::byteT attrReg [tpmCrbPkg::MaxSessions];
	tpmCrbPkg::halfT hmacSizeReg [tpmCrbPkg::MaxSessions];
	tpmCrbPkg::halfT nonceSize; // current session only, never exported
	tpmCrbPkg::wordT rcHold; // response code for the response stream
	tpmCrbPkg::halfT rspTag;
	tpmCrbPkg::bufAddrT paramSize; // bytes left up to cmdSize
	logic [79:0] rspImage;
	logic [2:0] sessValid;
	logic [2:0] sessMask; // first sessionCount bits

	// drop one byte into a big-endian word, pos 0 is the msb
	function automatic tpmCrbPkg::wordT putByte(tpmCrbPkg::wordT word, logic [1:0] pos,
		tpmCrbPkg::byteT value);
		tpmCrbPkg::wordT result;
		result = word;
		result[8 * (3 - pos) +: 8] = value;
		return result;
	endfunction

	assign paramSize = (cmdSize > 32'(xferAddr)) ? cmdSize[11:0] - xferAddr : '0;
	assign sessMask = {sessionCount > 3'd2, sessionCount > 3'd1, sessionCount > 3'd0};

	// control path
	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= tpmCrbPkg::SeqIdle;
			idx <= '0;
			xferStart <= 1'b0;
			xferSize <= '0;
			sessValid <= '0;
		end
		else
		begin
			xferStart <= 1'b0; // pulse by default
			case (state)
				tpmCrbPkg::SeqIdle:
					if (cmdSend)
					begin
						sessValid <= '0;
						xferStart <= 1'b1;
						xferSize <= tpmCrbPkg::HeaderBytes;
						state <= tpmCrbPkg::SeqHeader;
					end
				tpmCrbPkg::SeqHeader:
					if (xferDone)
					begin
						idx <= '0;
						// unknown code skips straight to the exec handshake
						state <= codeValid ? tpmCrbPkg::SeqHandleCheck : tpmCrbPkg::SeqExecGo;
					end
				tpmCrbPkg::SeqHandleCheck:
				begin
					xferStart <= 1'b1; // every exit opens a transfer
					if (idx < handleCount)
					begin
						xferSize <= tpmCrbPkg::HandleBytes;
						state <= tpmCrbPkg::SeqHandle;
					end
					else if (sessionCount != '0)
					begin
						idx <= '0; // reused for sessions
						xferSize <= tpmCrbPkg::AuthSizeBytes;
						state <= tpmCrbPkg::SeqAuth;
					end
					else
					begin
						xferSize <= paramSize;
						state <= tpmCrbPkg::SeqParam;
					end
				end
				tpmCrbPkg::SeqHandle:
					if (xferDone)
					begin
						idx <= idx + 3'd1;
						state <= tpmCrbPkg::SeqHandleCheck;
					end
				tpmCrbPkg::SeqAuth:
					if (xferDone)
						state <= tpmCrbPkg::SeqSessionCheck;
				tpmCrbPkg::SeqSessionCheck:
				begin
					xferStart <= 1'b1;
					if (idx < sessionCount)
					begin
						xferSize <= tpmCrbPkg::SessionHeadBytes;
						state <= tpmCrbPkg::SeqSessionHead;
					end
					else
					begin
						xferSize <= paramSize;
						state <= tpmCrbPkg::SeqParam;
					end
				end
				tpmCrbPkg::SeqSessionHead:
					if (xferDone)
					begin
						xferStart <= 1'b1;
						xferSize <= nonceSize[11:0]; // nonce bytes skipped
						state <= tpmCrbPkg::SeqNonce;
					end
				tpmCrbPkg::SeqNonce:
					if (xferDone)
					begin
						xferStart <= 1'b1;
						xferSize <= tpmCrbPkg::SessionTailBytes;
						state <= tpmCrbPkg::SeqSessionTail;
					end
				tpmCrbPkg::SeqSessionTail:
					if (xferDone)
					begin
						xferStart <= 1'b1;
						xferSize <= hmacSizeReg[idx[1:0]][11:0];
						state <= tpmCrbPkg::SeqHmac;
					end
				tpmCrbPkg::SeqHmac:
					if (xferDone)
					begin
						idx <= idx + 3'd1;
						state <= tpmCrbPkg::SeqSessionCheck;
					end
				tpmCrbPkg::SeqParam:
					if (xferDone)
					begin
						sessValid <= sessMask; // visible together with execStart
						state <= tpmCrbPkg::SeqExecGo;
					end
				tpmCrbPkg::SeqExecGo:
					state <= (codeValid && engineCommand) ? tpmCrbPkg::SeqExecWait
						: tpmCrbPkg::SeqExecDone;
				tpmCrbPkg::SeqExecWait:
					if (rspReady)
						state <= tpmCrbPkg::SeqExecDone;
				tpmCrbPkg::SeqExecDone:
					if (execAck)
					begin
						xferStart <= 1'b1;
						xferSize <= tpmCrbPkg::HeaderBytes;
						state <= tpmCrbPkg::SeqResponse;
					end
				tpmCrbPkg::SeqResponse:
					if (xferDone)
						state <= tpmCrbPkg::SeqIdle;
				default: state <= tpmCrbPkg::SeqIdle;
			endcase
		end
	end

	// captured fields, big-endian by relative offset
	always_ff @(posedge clock)
	begin
		if (byteStrobe)
		begin
			case (state)
				tpmCrbPkg::SeqHeader:
					if (xferRel < 12'd2)
						commandTag[8 * (1 - xferRel[0]) +: 8] <= cmdByteIn;
					else if (xferRel >= 12'd6) // size bytes 2..5 come from cmdSize
						commandCode <= putByte(commandCode, 2'(xferRel - 12'd6), cmdByteIn);
				tpmCrbPkg::SeqHandle:
					handleReg[idx[1:0]] <= putByte(handleReg[idx[1:0]], xferRel[1:0], cmdByteIn);
				tpmCrbPkg::SeqAuth:
					authSize <= putByte(authSize, xferRel[1:0], cmdByteIn);
				tpmCrbPkg::SeqSessionHead:
					if (xferRel < 12'd4)
						sessHandleReg[idx[1:0]] <= putByte(sessHandleReg[idx[1:0]], xferRel[1:0],
							cmdByteIn);
					else
						nonceSize[8 * (1 - xferRel[0]) +: 8] <= cmdByteIn;
				tpmCrbPkg::SeqSessionTail:
					if (xferRel == '0)
						attrReg[idx[1:0]] <= cmdByteIn;
					else
						hmacSizeReg[idx[1:0]][8 * xferRel[0] +: 8] <= cmdByteIn; // rel 1 msb
				default: ;
			endcase
		end
		// rc source depends on the processor
		if (state == tpmCrbPkg::SeqExecGo && !codeValid)
			rcHold <= tpmCrbPkg::RcCommandCode;
		else if (state == tpmCrbPkg::SeqExecWait && rspReady)
			rcHold <= responseCode;
		else if (state == tpmCrbPkg::SeqExecDone && execAck && codeValid && !engineCommand)
			rcHold <= responseCode;
	end

	// response image, tag falls back on failure
	assign rspTag = (rcHold == tpmCrbPkg::RcSuccess) ? commandTag : tpmCrbPkg::StNoSessions;
	assign rspImage = {rspTag, 20'h0, tpmCrbPkg::HeaderBytes, rcHold};
	assign rspByteOut = (xferAddr < tpmCrbPkg::HeaderBytes) ? rspImage[8 * (9 - xferAddr) +: 8]
		: '0;

	assign rspSend = (state == tpmCrbPkg::SeqResponse) && byteStrobe;
	assign rspDone = (state == tpmCrbPkg::SeqResponse) && xferDone;
	assign cmdDone = state == tpmCrbPkg::SeqExecGo;
	assign execStart = (state == tpmCrbPkg::SeqExecGo) && codeValid;
	assign execDone = state == tpmCrbPkg::SeqExecDone;
	assign xferRestart = (state == tpmCrbPkg::SeqIdle) || (state == tpmCrbPkg::SeqExecGo);
	assign cmdOutAddr = xferAddr;
	assign rspOutAddr = xferAddr; // rewound to 0 before the response

	assign {handle0, handle1, handle2} = {handleReg[0], handleReg[1], handleReg[2]};
	assign {sessionHandle0, sessionHandle1, sessionHandle2} =
		{sessHandleReg[0], sessHandleReg[1], sessHandleReg[2]};
	assign {sessionAttributes0, sessionAttributes1, sessionAttributes2} =
		{attrReg[0], attrReg[1], attrReg[2]};
	assign {sessionHmacSize0, sessionHmacSize1, sessionHmacSize2} =
		{hmacSizeReg[0], hmacSizeReg[1], hmacSizeReg[2]};
	assign {sessionValid0, sessionValid1, sessionValid2} = {sessValid[0], sessValid[1], sessValid[2]};

	// no second execStart before this command's execDone
	execStartOnce: assert property (@(posedge clock) disable iff (!reset_n)
		execStart |=> (!execStart throughout execDone[->1]));

	tableCountBound: assert property (@(posedge clock) disable iff (!reset_n)
		codeValid |-> (sessionCount <= tpmCrbPkg::MaxSessions &&
		handleCount <= tpmCrbPkg::MaxHandles));

endmodule

/* crbTransfer.sv */
//==============================
// crb byte transfer sequencer
// paced byte strobes over a running buffer offset
//==============================
`timescale 1ns/1ps

module crbTransfer (
	input logic clock,
	input logic reset_n,
	input logic start, // one cycle kick
	input logic restart, // level, rewinds everything to offset 0
	input tpmCrbPkg::bufAddrT size, // read in Setup
	output tpmCrbPkg::bufAddrT addr, // absolute offset
	output tpmCrbPkg::bufAddrT rel, // offset within this transfer
	output logic byteStrobe,
	output logic done
);

	tpmCrbPkg::xferStateT state;
	tpmCrbPkg::xferStateT nextState;
	tpmCrbPkg::bufAddrT endOff; // running end, grows by size each transfer
	tpmCrbPkg::bufAddrT startOff; // where the current transfer began

	always_comb
	begin
		case (state)
			tpmCrbPkg::XferIdle: nextState = start ? tpmCrbPkg::XferSetup : tpmCrbPkg::XferIdle;
			tpmCrbPkg::XferSetup: nextState = (size == '0) ? tpmCrbPkg::XferDone : tpmCrbPkg::XferFetch0;
			tpmCrbPkg::XferFetch0: nextState = tpmCrbPkg::XferFetch1;
			tpmCrbPkg::XferFetch1: nextState = tpmCrbPkg::XferAdvance;
			// last byte when the bumped address hits the end
			tpmCrbPkg::XferAdvance:
				nextState = (addr + 12'd1 == endOff) ? tpmCrbPkg::XferDone : tpmCrbPkg::XferFetch0;
			default: nextState = tpmCrbPkg::XferIdle; // Done returns to Idle
		endcase
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= tpmCrbPkg::XferIdle;
			addr <= '0;
			endOff <= '0;
			startOff <= '0;
		end
		else
		begin
			state <= nextState;
			if (restart)
			begin
				addr <= '0;
				endOff <= '0;
				startOff <= '0;
			end
			else if (state == tpmCrbPkg::XferSetup)
			begin
				startOff <= endOff; // new window opens at old end
				endOff <= endOff + size;
			end
			else if (state == tpmCrbPkg::XferAdvance)
				addr <= addr + 12'd1;
		end
	end

	assign byteStrobe = state == tpmCrbPkg::XferFetch1;
	assign done = state == tpmCrbPkg::XferDone;
	assign rel = addr - startOff;

	// each strobe falls inside the open window
	strobeInWindow: assert property (@(posedge clock) disable iff (!reset_n)
		byteStrobe |-> (addr >= startOff && addr < endOff));

	addrBounded: assert property (@(posedge clock) disable iff (!reset_n)
		addr <= endOff);

endmodule

/* run.sh */
#!/usr/bin/env bash
# compile and run the tpmCrb testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tpmCrb.f --top-module tpmCrbTb -o tpmCrbSim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/tpmCrbSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -Fxq '*** PASSED ***' "$LOG"; then
	exit 0
fi
exit 1

/* tpmCrb.f */
tpmCrbPkg.sv
crbTransfer.sv
crbCommandTable.sv
crbSequencer.sv
tpmCrb.sv
tpmCrbChecker.sv
tpmCrbTb.sv

/* tpmCrb.sv */
//==============================
// tpm command/response buffer
// sequencer, transfer sequencer, command table
//==============================
`timescale 1ns/1ps

module tpmCrb (
	input logic clock,
	input logic reset_n,
	input logic cmdSend,
	input logic rspReady,
	input logic execAck,
	input tpmCrbPkg::wordT cmdSize,
	input tpmCrbPkg::wordT responseCode,
	input tpmCrbPkg::byteT cmdByteIn,
	output tpmCrbPkg::bufAddrT cmdOutAddr,
	output tpmCrbPkg::bufAddrT rspOutAddr,
	output tpmCrbPkg::byteT rspByteOut,
	output logic rspSend, cmdDone, rspDone, execStart, execDone,
	output tpmCrbPkg::halfT commandTag,
	output tpmCrbPkg::wordT handle0, handle1, handle2,
	output tpmCrbPkg::wordT sessionHandle0, sessionHandle1, sessionHandle2,
	output tpmCrbPkg::wordT authSize,
	output tpmCrbPkg::byteT sessionAttributes0, sessionAttributes1, sessionAttributes2,
	output tpmCrbPkg::halfT sessionHmacSize0, sessionHmacSize1, sessionHmacSize2,
	output logic sessionValid0, sessionValid1, sessionValid2
);

	// transfer sequencer link
	logic xferStart, xferRestart, byteStrobe, xferDone;
	tpmCrbPkg::bufAddrT xferSize, xferAddr, xferRel;

	// command table link
	tpmCrbPkg::wordT commandCode;
	tpmCrbPkg::countT handleCount, sessionCount;
	logic codeValid, engineCommand;

	crbSequencer sequencer_i (.*); // names match one to one

	crbTransfer transfer_i (
		.clock(clock),
		.reset_n(reset_n),
		.start(xferStart),
		.restart(xferRestart),
		.size(xferSize),
		.addr(xferAddr),
		.rel(xferRel),
		.byteStrobe(byteStrobe),
		.done(xferDone)
	);

	crbCommandTable table_i (.*); // purely combinational lookup

endmodule

/* tpmCrbChecker.sv */
//==============================
// tpm crb checker
// reference parse of the command image
// compares captured fields and the response bytes
//==============================
`timescale 1ns/1ps

module tpmCrbChecker (
	input logic clock,
	input logic reset_n,
	input tpmCrbPkg::byteT image [256], // command as built by the testbench
	input int cmdLen,
	input tpmCrbPkg::wordT responseCode, // chosen by the executor model
	input tpmCrbPkg::bufAddrT cmdOutAddr,
	input tpmCrbPkg::bufAddrT rspOutAddr,
	input tpmCrbPkg::byteT rspByteOut,
	input logic rspSend, cmdDone, rspDone, execStart, execDone, execAck,
	input tpmCrbPkg::halfT commandTag,
	input tpmCrbPkg::wordT handle0, handle1, handle2,
	input tpmCrbPkg::wordT sessionHandle0, sessionHandle1, sessionHandle2,
	input tpmCrbPkg::wordT authSize,
	input tpmCrbPkg::byteT sessionAttributes0, sessionAttributes1, sessionAttributes2,
	input tpmCrbPkg::halfT sessionHmacSize0, sessionHmacSize1, sessionHmacSize2,
	input logic sessionValid0, sessionValid1, sessionValid2,
	output int errorCount,
	output int testCount
);

	tpmCrbPkg::wordT expCode, expAuth, expRc;
	tpmCrbPkg::wordT expHandle [3];
	tpmCrbPkg::wordT expSessHandle [3];
	tpmCrbPkg::byteT expAttr [3];
	tpmCrbPkg::halfT expHmac [3];
	tpmCrbPkg::byteT expRsp [10];
	logic [2:0] hc, sc; // counts from the table
	logic [2:0] expValid;
	logic expExec; // code known so execStart expected
	logic expWait; // engine command waits for rspReady
	logic cmdDonePrev = 1'b0;
	logic execDonePrev = 1'b0;
	logic execAckPrev = 1'b0;
	int expEnd; // cmdOutAddr when parsing ends
	int rspCount;
	int testErrors;
	int errors = 0;
	int tests = 0;

	assign errorCount = errors;
	assign testCount = tests;

	// big-endian word out of the image
	function automatic tpmCrbPkg::wordT wordAt(int p);
		return {image[p], image[p + 1], image[p + 2], image[p + 3]};
	endfunction

	function automatic void computeExpected();
		int i;
		int p;
		tpmCrbPkg::halfT tag;
		expCode = wordAt(6);
		expExec = 1'b1;
		case (expCode)
			tpmCrbPkg::CcStartup,
			tpmCrbPkg::CcSelfTest,
			tpmCrbPkg::CcGetRandom: {hc, sc} = {3'd0, 3'd0};
			tpmCrbPkg::CcClear,
			tpmCrbPkg::CcHierarchyControl: {hc, sc} = {3'd1, 3'd1};
			tpmCrbPkg::CcNvRead: {hc, sc} = {3'd2, 3'd1};
			tpmCrbPkg::CcActivateCredential: {hc, sc} = {3'd2, 3'd2};
			tpmCrbPkg::CcPolicyNV: {hc, sc} = {3'd3, 3'd1};
			default:
			begin
				{hc, sc} = {3'd0, 3'd0};
				expExec = 1'b0; // unknown code stops after the header
			end
		endcase
		// management commands skip the engine
		expWait = expExec && expCode != tpmCrbPkg::CcStartup &&
			expCode != tpmCrbPkg::CcHierarchyControl;
		p = 10; // first byte after the header
		for (i = 0; i < 3; i++)
			expValid[i] = i < int'(sc);
		for (i = 0; i < int'(hc); i++)
		begin
			expHandle[i] = wordAt(p);
			p = p + 4;
		end
		if (sc != 3'd0)
		begin
			expAuth = wordAt(p);
			p = p + 4;
		end
		for (i = 0; i < int'(sc); i++)
		begin
			expSessHandle[i] = wordAt(p);
			p = p + 6 + int'({image[p + 4], image[p + 5]}); // past the nonce
			expAttr[i] = image[p];
			expHmac[i] = {image[p + 1], image[p + 2]};
			p = p + 3 + int'(expHmac[i]); // past the hmac
		end
		expEnd = expExec ? cmdLen : 10;
		expRc = expExec ? responseCode : tpmCrbPkg::RcCommandCode;
		tag = (expRc == tpmCrbPkg::RcSuccess) ? {image[0], image[1]} : tpmCrbPkg::StNoSessions;
		expRsp[0] = tag[15:8];
		expRsp[1] = tag[7:0];
		for (i = 0; i < 4; i++)
		begin
			expRsp[2 + i] = (i == 3) ? 8'd10 : 8'd0; // size is always 10
			expRsp[6 + i] = expRc[31 - 8 * i -: 8];
		end
	endfunction

	task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
			errors++;
			testErrors++;
		end
	endtask

	task automatic checkSession(int i, tpmCrbPkg::wordT h, tpmCrbPkg::byteT a,
		tpmCrbPkg::halfT m);
		checkValue($sformatf("sessionHandle%0d", i), h, expSessHandle[i]);
		checkValue($sformatf("sessionAttributes%0d", i), a, expAttr[i]);
		checkValue($sformatf("sessionHmacSize%0d", i), m, expHmac[i]);
	endtask

	// sampled mid cycle when all outputs have settled
	always @(negedge clock)
	begin
		if (reset_n)
		begin
			if (execStart && !cmdDone)
			begin
				$display("execStart at %0t came outside the end of parsing", $time);
				errors++;
			end
			// no engine wait means execDone right after cmdDone
			if (cmdDonePrev)
				checkValue("execDone", execDone, !expWait);
			if (execDonePrev && !execAckPrev && !execDone)
			begin
				$display("execDone dropped at %0t before execAck was given", $time);
				errors++;
				testErrors++;
			end
			if (cmdDone)
			begin
				testErrors = 0;
				rspCount = 0;
				computeExpected();
				checkValue("execStart", execStart, expExec);
				checkValue("cmdOutAddr", cmdOutAddr, expEnd); // all bytes consumed
				checkValue("commandTag", commandTag, {image[0], image[1]});
				checkValue("sessionValid", {sessionValid2, sessionValid1, sessionValid0}, expValid);
				if (hc > 3'd0)
					checkValue("handle0", handle0, expHandle[0]);
				if (hc > 3'd1)
					checkValue("handle1", handle1, expHandle[1]);
				if (hc > 3'd2)
					checkValue("handle2", handle2, expHandle[2]);
				if (sc > 3'd0)
				begin
					checkValue("authSize", authSize, expAuth);
					checkSession(0, sessionHandle0, sessionAttributes0, sessionHmacSize0);
				end
				if (sc > 3'd1)
					checkSession(1, sessionHandle1, sessionAttributes1, sessionHmacSize1);
				if (sc > 3'd2)
					checkSession(2, sessionHandle2, sessionAttributes2, sessionHmacSize2);
			end
			if (rspSend)
			begin
				if (rspCount < 10)
				begin
					checkValue("rspOutAddr", rspOutAddr, rspCount);
					checkValue("rspByteOut", rspByteOut, expRsp[rspCount]);
				end
				else
				begin
					$display("response byte %0d at %0t is beyond the 10 byte response", rspCount, $time);
					errors++;
					testErrors++;
				end
				rspCount++;
			end
			if (rspDone)
			begin
				if (rspCount != 10)
				begin
					$display("response ended after %0d bytes instead of 10", rspCount);
					errors++;
					testErrors++;
				end
				tests++;
				$display("test %0d code %h: %0d mismatches", tests, expCode, testErrors);
			end
			cmdDonePrev = cmdDone;
			execDonePrev = execDone;
			execAckPrev = execAck;
		end
	end

endmodule

/* tpmCrbPkg.sv */
//==============================
// tpm crb shared definitions
// widths, tpm constants, field sizes and fsm states
//==============================
package tpmCrbPkg;

	// widths with a meaning
	typedef logic [7:0] byteT; // one buffer byte
	typedef logic [11:0] bufAddrT; // command or response buffer offset
	typedef logic [31:0] wordT; // code, handles, rc, size
	typedef logic [15:0] halfT; // tag, hmac size
	typedef logic [2:0] countT; // handle or session count

	localparam countT MaxHandles = 3'd3;
	localparam countT MaxSessions = 3'd3;

	// field sizes in bytes
	localparam bufAddrT HeaderBytes = 12'd10; // also the whole response
	localparam bufAddrT HandleBytes = 12'd4;
	localparam bufAddrT AuthSizeBytes = 12'd4;
	localparam bufAddrT SessionHeadBytes = 12'd6; // session handle + nonce size
	localparam bufAddrT SessionTailBytes = 12'd3; // attributes + hmac size

	// structure tags
	localparam halfT StNoSessions = 16'h8001;
	localparam halfT StSessions = 16'h8002;

	// response codes
	localparam wordT RcSuccess = 32'h0000_0000;
	localparam wordT RcCommandCode = 32'h0000_0143; // unknown command

	// supported command codes
	localparam wordT CcHierarchyControl = 32'h0000_0121;
	localparam wordT CcClear = 32'h0000_0126;
	localparam wordT CcSelfTest = 32'h0000_0143;
	localparam wordT CcStartup = 32'h0000_0144;
	localparam wordT CcActivateCredential = 32'h0000_0147;
	localparam wordT CcPolicyNV = 32'h0000_0149;
	localparam wordT CcNvRead = 32'h0000_014E;
	localparam wordT CcGetRandom = 32'h0000_017B;

	// byte transfer sequencer
	typedef enum logic [2:0] {
		XferIdle,
		XferSetup, // latch window
		XferFetch0,
		XferFetch1, // byte strobe
		XferAdvance,
		XferDone
	} xferStateT;

	// command parse, exec and response
	typedef enum logic [3:0] {
		SeqIdle,
		SeqHeader,
		SeqHandleCheck,
		SeqHandle,
		SeqAuth,
		SeqSessionCheck,
		SeqSessionHead,
		SeqNonce, // skipped
		SeqSessionTail,
		SeqHmac, // skipped
		SeqParam, // skipped up to cmdSize
		SeqExecGo,
		SeqExecWait,
		SeqExecDone,
		SeqResponse
	} crbStateT;

endpackage

/* tpmCrbTb.sv */
//==============================
// tpm crb testbench
// command images, buffer model, executor model, stimulus
//==============================
`timescale 1ns/1ps

module tpmCrbTb;

	localparam int TestCount = 17; // five directed, twelve random
	localparam int CycleLimit = 20 * 400; // up to 20 commands at 400 cycles each

	logic clock = 1'b0;
	logic reset_n, cmdSend, rspReady, execAck;
	tpmCrbPkg::wordT cmdSize, responseCode;
	tpmCrbPkg::byteT cmdByteIn;
	tpmCrbPkg::bufAddrT cmdOutAddr, rspOutAddr;
	tpmCrbPkg::byteT rspByteOut;
	logic rspSend, cmdDone, rspDone, execStart, execDone;
	tpmCrbPkg::halfT commandTag;
	tpmCrbPkg::wordT handle0, handle1, handle2;
	tpmCrbPkg::wordT sessionHandle0, sessionHandle1, sessionHandle2;
	tpmCrbPkg::wordT authSize;
	tpmCrbPkg::byteT sessionAttributes0, sessionAttributes1, sessionAttributes2;
	tpmCrbPkg::halfT sessionHmacSize0, sessionHmacSize1, sessionHmacSize2;
	logic sessionValid0, sessionValid1, sessionValid2;
	tpmCrbPkg::byteT image [256]; // command buffer model
	int cmdLen, wp, errorCount, testCount;
	int cycles = 0;
	int tbErrors = 0;
	int seed = 16;
	// stimulus copy of the command table
	tpmCrbPkg::wordT codes [8] = '{32'h144, 32'h143, 32'h17B, 32'h126, 32'h121, 32'h14E,
		32'h147, 32'h149};
	int handleCounts [8] = '{0, 0, 0, 1, 1, 2, 2, 3};
	int sessionCounts [8] = '{0, 0, 0, 1, 1, 1, 2, 1};

	tpmCrb dut_i (.*);
	tpmCrbChecker checker_i (.*);

	always #2 clock = ~clock; // 4 ns period

	assign cmdByteIn = image[cmdOutAddr[7:0]]; // served combinationally

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= CycleLimit)
		begin
			$display("timeout, the run did not finish within %0d cycles", CycleLimit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic nextCycle();
		@(posedge clock);
		#1; // drive just after the edge
	endtask

	task automatic fillImage();
		int i;
		for (i = 0; i < 256; i++)
			image[i] = 8'(i * 7 + 3); // odd stride, every offset distinct
	endtask

	// big-endian, at the write pointer
	task automatic appendBytes(input logic [31:0] value, input int count);
		int i;
		for (i = count - 1; i >= 0; i--)
		begin
			image[wp] = value[8 * i +: 8];
			wp++;
		end
	endtask

	task automatic buildCommand(input tpmCrbPkg::halfT tag, input tpmCrbPkg::wordT code,
		input int hc, input int sc, input int nonceLen, input int hmacLen, input int paramLen);
		int i;
		fillImage();
		wp = 0;
		appendBytes(tag, 2);
		wp = 6; // size goes in last
		appendBytes(code, 4);
		for (i = 0; i < hc; i++)
			appendBytes($random(seed), 4);
		if (sc != 0)
			appendBytes($random(seed), 4); // auth size
		for (i = 0; i < sc; i++)
		begin
			appendBytes($random(seed), 4);
			appendBytes(nonceLen, 2);
			wp += nonceLen; // nonce left as fill
			appendBytes($random(seed), 1);
			appendBytes(hmacLen, 2);
			wp += hmacLen;
		end
		cmdLen = wp + paramLen; // params are fill too
		wp = 2;
		appendBytes(cmdLen, 4);
	endtask

	// host strobe plus executor model
	task automatic runCommand(input tpmCrbPkg::wordT rc);
		int delay;
		cmdSize = cmdLen;
		responseCode = rc;
		cmdSend = 1'b1;
		nextCycle();
		cmdSend = 1'b0;
		while (!cmdDone)
			nextCycle();
		delay = $unsigned($random(seed)) % 24; // engine latency
		repeat (delay)
			nextCycle();
		if (!execDone)
			rspReady = 1'b1;
		while (!execDone)
			nextCycle();
		rspReady = 1'b0;
		delay = $unsigned($random(seed)) % 8;
		repeat (delay)
			nextCycle();
		execAck = 1'b1;
		nextCycle();
		execAck = 1'b0;
		while (!rspDone)
			nextCycle();
		nextCycle(); // sequencer back in Idle
	endtask

	initial
	begin
		int n;
		int k;
		int nonceLen;
		int hmacLen;
		int paramLen;
		tpmCrbPkg::wordT rc;
		reset_n = 1'b0;
		cmdSend = 1'b0;
		rspReady = 1'b0;
		execAck = 1'b0;
		cmdSize = '0;
		responseCode = '0;
		fillImage();
		repeat (4)
			@(posedge clock);
		#1;
		reset_n = 1'b1;
		if ({execStart, execDone, cmdDone, rspDone, rspSend,
			sessionValid0, sessionValid1, sessionValid2} != '0)
		begin
			$display("control outputs are not low after reset");
			tbErrors++;
		end
		nextCycle();
		// directed: startup, clear, activate credential, policy nv, unknown code
		buildCommand(tpmCrbPkg::StNoSessions, tpmCrbPkg::CcStartup, 0, 0, 0, 0, 2);
		runCommand(tpmCrbPkg::RcSuccess);
		buildCommand(tpmCrbPkg::StSessions, tpmCrbPkg::CcClear, 1, 1, 5, 8, 0);
		runCommand(tpmCrbPkg::RcSuccess);
		buildCommand(tpmCrbPkg::StSessions, tpmCrbPkg::CcActivateCredential, 2, 2, 4, 6, 4);
		runCommand(32'h0000_098E); // failure, tag falls back
		buildCommand(tpmCrbPkg::StSessions, tpmCrbPkg::CcPolicyNV, 3, 1, 3, 2, 6);
		runCommand(tpmCrbPkg::RcSuccess);
		buildCommand(tpmCrbPkg::StNoSessions, 32'h0000_0199, 0, 0, 0, 0, 0);
		runCommand(tpmCrbPkg::RcSuccess);
		// random back to back
		for (n = 0; n < 12; n++)
		begin
			k = $unsigned($random(seed)) % 8;
			nonceLen = $unsigned($random(seed)) % 9;
			hmacLen = $unsigned($random(seed)) % 9;
			paramLen = $unsigned($random(seed)) % 9;
			rc = ($unsigned($random(seed)) % 4 == 0) ? 32'h0000_0100 + $unsigned($random(seed)) % 64
				: tpmCrbPkg::RcSuccess;
			buildCommand((sessionCounts[k] != 0) ? tpmCrbPkg::StSessions : tpmCrbPkg::StNoSessions,
				codes[k], handleCounts[k], sessionCounts[k], nonceLen, hmacLen, paramLen);
			runCommand(rc);
		end
		$display("%0d of %0d tests done, %0d errors", testCount, TestCount, errorCount + tbErrors);
		if (errorCount == 0 && tbErrors == 0 && testCount == TestCount)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			if (testCount != TestCount)
				$display("not every command reached the end of its response");
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
